//--- Makefile
# Verilator build of the execution back end testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -j 0
TOP       = exec_backend_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
+incdir+src
src/exec_pkg.sv
src/stage_ifs.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/exec_backend.sv
verification/exec_backend_tb.sv

//--- src/decode_stage.sv
/*
 * decode_stage: splits the issued word by opcode into unit kind,
 * ALU op and operands, registered onto the issue bus
 */

module decode_stage (
	input  logic                clk,
	input  logic                reset,
	input  logic                issue_valid,
	input  exec_pkg::instr_word_u instr,
	input  exec_pkg::xlen_t     rs1_data,
	input  exec_pkg::xlen_t     rs2_data,
	input  exec_pkg::tag_t      rd_tag,
	issue_if.producer           dec
);
	import exec_pkg::*;

	unit_kind_e kind_d;
	alu_op_e    alu_op_d;
	xlen_t      op_b_d;
	logic       known_d;

	always_comb begin
		kind_d   = UNIT_ALU;
		alu_op_d = ZERO;
		op_b_d   = rs2_data;
		known_d  = 1'b1;
		case (instr.r.opcode)
			R_TYPE: begin
				case (instr.r.func3)
					3'h0: begin
						if (instr.r.func7 == 7'h00)
							alu_op_d = ADD;
						else if (instr.r.func7 == 7'h20)
							alu_op_d = SUB;
					end
					3'h4: alu_op_d = XOR;
					3'h6: alu_op_d = OR;
					3'h7: alu_op_d = AND;
					default: alu_op_d = ZERO;
				endcase
			end
			I_TYPE: begin
				op_b_d = xlen_t'($signed(instr.i.imm));
				case (instr.i.func3)
					3'h0: alu_op_d = ADD;
					3'h4: alu_op_d = XOR;
					3'h6: alu_op_d = OR;
					3'h7: alu_op_d = AND;
					default: alu_op_d = ZERO;
				endcase
			end
			LUI_TYPE: begin
				op_b_d   = {instr.u.imm, 12'h000};
				alu_op_d = PASS_B;
			end
			LOAD_TYPE: begin
				kind_d   = UNIT_LOAD;
				alu_op_d = ADD;
				op_b_d   = xlen_t'($signed(instr.i.imm));
			end
			STORE_TYPE: begin
				kind_d   = UNIT_STORE;
				alu_op_d = ADD;
				op_b_d   = xlen_t'($signed({instr.s.imm_hi, instr.s.imm_lo}));
			end
			// compares rs1 against rs2, target is resolved elsewhere
			BRANCH_TYPE: kind_d = UNIT_BRANCH;
			default: known_d = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			dec.valid <= 1'b0;
		else
			dec.valid <= issue_valid && known_d;
	end

	always_ff @(posedge clk) begin
		dec.kind       <= kind_d;
		dec.alu_op     <= alu_op_d;
		dec.op_a       <= rs1_data;
		dec.op_b       <= op_b_d;
		dec.store_data <= rs2_data;
		dec.rd_tag     <= rd_tag;
		dec.func3      <= instr.r.func3;
	end

endmodule

//--- src/exec_backend.sv
/*
 * exec_backend: decode, execute and memory stages joined by
 * the two stage buses, result out on the CDB
 */

module exec_backend (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  issue_valid,
	input  exec_pkg::instr_word_u instr,
	input  exec_pkg::xlen_t       rs1_data,
	input  exec_pkg::xlen_t       rs2_data,
	input  exec_pkg::tag_t        rd_tag,
	output logic                  cdb_valid,
	output exec_pkg::tag_t        cdb_tag,
	output exec_pkg::xlen_t       cdb_data,
	output logic                  cdb_branch,
	output logic                  cdb_branch_taken
);

	issue_if  issue_bus ();
	result_if result_bus ();

	decode_stage decode_i (
		.clk         (clk),
		.reset       (reset),
		.issue_valid (issue_valid),
		.instr       (instr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.rd_tag      (rd_tag),
		.dec         (issue_bus.producer)
	);

	execute_stage execute_i (
		.clk   (clk),
		.reset (reset),
		.dec   (issue_bus.consumer),
		.exe   (result_bus.producer)
	);

	// CDB is driven straight from the last stage registers
	memory_stage memory_i (
		.clk              (clk),
		.reset            (reset),
		.exe              (result_bus.consumer),
		.cdb_valid        (cdb_valid),
		.cdb_branch       (cdb_branch),
		.cdb_branch_taken (cdb_branch_taken),
		.cdb_tag          (cdb_tag),
		.cdb_data         (cdb_data)
	);

endmodule

//--- src/exec_cfg.svh
/*
 * global sizes for the execution back end:
 * data and tag widths, data memory depth and base address
 */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// data word width
`define XLEN 32

// CDB tag width
`define TAG_W 6

// data memory, word count and byte address of word 0
`define DMEM_WORDS 32
`define DMEM_BASE 32'h1001_0000

`endif

//--- src/exec_pkg.sv
/*
 * shared types: data and tag words, opcode, unit kind and ALU op enums,
 * the four RV32 instruction layouts and the union over them
 */
`include "exec_cfg.svh"

package exec_pkg;

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [`TAG_W-1:0] tag_t;

	// opcodes handled by this back end
	typedef enum logic [6:0] {
		R_TYPE      = 7'h33,
		I_TYPE      = 7'h13,
		LUI_TYPE    = 7'h37,
		LOAD_TYPE   = 7'h03,
		STORE_TYPE  = 7'h23,
		BRANCH_TYPE = 7'h63
	} opcode_e;

	// which path the result takes to the CDB
	typedef enum logic [1:0] {
		UNIT_ALU,
		UNIT_BRANCH,
		UNIT_LOAD,
		UNIT_STORE
	} unit_kind_e;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		XOR,
		OR,
		AND,
		PASS_B,
		ZERO
	} alu_op_e;

	typedef struct packed {
		logic [6:0] func7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  func3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	// store immediate is split around rs2/rs1
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	// one instruction word, read in the view the opcode selects
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
	} instr_word_u;

endpackage

//--- src/execute_stage.sv
/*
 * execute_stage: ALU, BEQ/BNE compare and load/store address,
 * registered onto the result bus
 */

module execute_stage (
	input  logic       clk,
	input  logic       reset,
	issue_if.consumer  dec,
	result_if.producer exe
);
	import exec_pkg::*;

	xlen_t sum;
	xlen_t alu_res;
	xlen_t value_d;
	logic  taken_d;

	// one adder serves ADD and the effective address
	assign sum = dec.op_a + dec.op_b;

	always_comb begin
		case (dec.alu_op)
			ADD:     alu_res = sum;
			SUB:     alu_res = dec.op_a - dec.op_b;
			XOR:     alu_res = dec.op_a ^ dec.op_b;
			OR:      alu_res = dec.op_a | dec.op_b;
			AND:     alu_res = dec.op_a & dec.op_b;
			PASS_B:  alu_res = dec.op_b;
			default: alu_res = '0;
		endcase
	end

	// BEQ / BNE only, other conditions fall through as not taken
	always_comb begin
		case (dec.func3)
			3'h0:    taken_d = (dec.op_a == dec.op_b);
			3'h1:    taken_d = (dec.op_a != dec.op_b);
			default: taken_d = 1'b0;
		endcase
	end

	always_comb begin
		if (dec.kind == UNIT_LOAD || dec.kind == UNIT_STORE)
			value_d = sum;
		else
			value_d = alu_res;
	end

	always_ff @(posedge clk) begin
		if (reset)
			exe.valid <= 1'b0;
		else
			exe.valid <= dec.valid;
	end

	always_ff @(posedge clk) begin
		exe.kind       <= dec.kind;
		exe.value      <= value_d;
		exe.store_data <= dec.store_data;
		exe.rd_tag     <= dec.rd_tag;
		exe.taken      <= taken_d && (dec.kind == UNIT_BRANCH);
	end

endmodule

//--- src/memory_stage.sv
/*
 * memory_stage: data memory with word-indexed loads and stores,
 * and the registered CDB outputs
 */
`include "exec_cfg.svh"

module memory_stage (
	input  logic            clk,
	input  logic            reset,
	result_if.consumer      exe,
	output logic            cdb_valid,
	output logic            cdb_branch,
	output logic            cdb_branch_taken,
	output exec_pkg::tag_t  cdb_tag,
	output exec_pkg::xlen_t cdb_data
);
	import exec_pkg::*;

	localparam int IDX_W = $clog2(`DMEM_WORDS);

	xlen_t             dmem [`DMEM_WORDS];
	xlen_t             offset;
	logic [IDX_W-1:0]  idx;
	xlen_t             load_word;

	// byte offset from the base, word index wraps at the depth
	assign offset    = exe.value - `DMEM_BASE;
	assign idx       = offset[IDX_W+1:2];
	assign load_word = dmem[idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (exe.valid && exe.kind == UNIT_STORE) begin
			dmem[idx] <= exe.store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cdb_valid        <= 1'b0;
			cdb_branch       <= 1'b0;
			cdb_branch_taken <= 1'b0;
		end else begin
			cdb_valid        <= exe.valid && (exe.kind == UNIT_ALU || exe.kind == UNIT_LOAD);
			cdb_branch       <= exe.valid && exe.kind == UNIT_BRANCH;
			cdb_branch_taken <= exe.valid && exe.kind == UNIT_BRANCH && exe.taken;
		end
	end

	// branches and stores publish zero tag and data
	always_ff @(posedge clk) begin
		case (exe.kind)
			UNIT_ALU: begin
				cdb_tag  <= exe.rd_tag;
				cdb_data <= exe.value;
			end
			UNIT_LOAD: begin
				cdb_tag  <= exe.rd_tag;
				cdb_data <= load_word;
			end
			default: begin
				cdb_tag  <= '0;
				cdb_data <= '0;
			end
		endcase
	end

endmodule

//--- src/stage_ifs.sv
/*
 * stage-to-stage buses: issue_if (decode to execute)
 * and result_if (execute to memory)
 */

interface issue_if;
	import exec_pkg::*;

	logic       valid;
	unit_kind_e kind;
	alu_op_e    alu_op;
	xlen_t      op_a;
	xlen_t      op_b;
	xlen_t      store_data;
	tag_t       rd_tag;
	// branch condition select
	logic [2:0] func3;

	modport producer (output valid, kind, alu_op, op_a, op_b, store_data, rd_tag, func3);
	modport consumer (input valid, kind, alu_op, op_a, op_b, store_data, rd_tag, func3);
endinterface

interface result_if;
	import exec_pkg::*;

	logic       valid;
	unit_kind_e kind;
	// ALU result or effective address
	xlen_t      value;
	xlen_t      store_data;
	tag_t       rd_tag;
	logic       taken;

	modport producer (output valid, kind, value, store_data, rd_tag, taken);
	modport consumer (input valid, kind, value, store_data, rd_tag, taken);
endinterface

//--- verification/exec_backend_tb.sv
/*
 * testbench for the execution back end: clock, reset, stimulus table
 * with expected CDB values, CDB monitor, compare tasks and timeout
 */
`include "exec_cfg.svh"

module exec_backend_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import exec_pkg::*;

	localparam int N_ROWS = 21;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT = N_ROWS + RESET_CYCLES + 10;

	typedef enum logic [1:0] {
		EXP_RESULT,
		EXP_BRANCH,
		EXP_NONE
	} exp_kind_e;

	typedef struct {
		logic [31:0] word;
		xlen_t       a;
		xlen_t       b;
		tag_t        tag;
		exp_kind_e   kind;
		xlen_t       data;
		logic        taken;
	} row_t;

	logic        clk;
	logic        reset;
	logic        issue_valid;
	instr_word_u instr;
	xlen_t       rs1_data;
	xlen_t       rs2_data;
	tag_t        rd_tag;
	logic        cdb_valid;
	tag_t        cdb_tag;
	xlen_t       cdb_data;
	logic        cdb_branch;
	logic        cdb_branch_taken;

	row_t rows [N_ROWS];
	row_t exp_q [$];
	int   due_q [$];
	row_t cur;
	int   neg_cnt;
	int   cycles;

	exec_backend exec_backend_i (
		.clk              (clk),
		.reset            (reset),
		.issue_valid      (issue_valid),
		.instr            (instr),
		.rs1_data         (rs1_data),
		.rs2_data         (rs2_data),
		.rd_tag           (rd_tag),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_data         (cdb_data),
		.cdb_branch       (cdb_branch),
		.cdb_branch_taken (cdb_branch_taken)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// RV32 encoders, register numbers are don't-care for the back end
	function automatic logic [31:0] encode_r(logic [6:0] f7, logic [2:0] f3);
		return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33};
	endfunction

	function automatic logic [31:0] encode_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
		return {imm, 5'd1, f3, 5'd3, opc};
	endfunction

	function automatic logic [31:0] encode_s(logic [11:0] imm);
		return {imm[11:5], 5'd2, 5'd1, 3'h2, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encode_b(logic [2:0] f3);
		return {7'h00, 5'd2, 5'd1, f3, 5'h08, 7'h63};
	endfunction

	function automatic logic [31:0] encode_u(logic [19:0] imm);
		return {imm, 5'd3, 7'h37};
	endfunction

	function automatic xlen_t sext12(logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	task automatic set_row(input int idx, input logic [31:0] word, input xlen_t a, input xlen_t b,
			input tag_t tag, input exp_kind_e kind, input xlen_t data, input logic taken);
		rows[idx] = '{word, a, b, tag, kind, data, taken};
	endtask

	// random ALU operands, expected values from the ISA rules
	task automatic build_table();
		xlen_t ra [5];
		xlen_t rb [5];
		xlen_t st_data;
		for (int k = 0; k < 5; k++) begin
			ra[k] = $urandom;
			rb[k] = $urandom;
		end
		st_data = $urandom;
		set_row(0, encode_r(7'h00, 3'h0), ra[0], rb[0], 6'd1, EXP_RESULT, ra[0] + rb[0], 1'b0);
		set_row(1, encode_r(7'h20, 3'h0), ra[1], rb[1], 6'd2, EXP_RESULT, ra[1] - rb[1], 1'b0);
		set_row(2, encode_r(7'h00, 3'h4), ra[2], rb[2], 6'd3, EXP_RESULT, ra[2] ^ rb[2], 1'b0);
		set_row(3, encode_r(7'h00, 3'h6), ra[3], rb[3], 6'd4, EXP_RESULT, ra[3] | rb[3], 1'b0);
		set_row(4, encode_r(7'h00, 3'h7), ra[4], rb[4], 6'd5, EXP_RESULT, ra[4] & rb[4], 1'b0);
		// negative immediates
		set_row(5, encode_i(12'hffb, 3'h0, 7'h13), ra[0], rb[1], 6'd6, EXP_RESULT,
			ra[0] + sext12(12'hffb), 1'b0);
		set_row(6, encode_i(12'hf00, 3'h4, 7'h13), ra[1], rb[2], 6'd7, EXP_RESULT,
			ra[1] ^ sext12(12'hf00), 1'b0);
		set_row(7, encode_i(12'h800, 3'h6, 7'h13), ra[2], rb[3], 6'd8, EXP_RESULT,
			ra[2] | sext12(12'h800), 1'b0);
		set_row(8, encode_i(12'hff0, 3'h7, 7'h13), ra[3], rb[4], 6'd9, EXP_RESULT,
			ra[3] & sext12(12'hff0), 1'b0);
		set_row(9, encode_u(20'habcde), ra[4], rb[0], 6'd10, EXP_RESULT, 32'habcd_e000, 1'b0);
		// BEQ then BNE, equal and unequal operands
		set_row(10, encode_b(3'h0), ra[0], ra[0], 6'd11, EXP_BRANCH, '0, 1'b1);
		set_row(11, encode_b(3'h0), ra[0], ra[0] ^ 32'h1, 6'd12, EXP_BRANCH, '0, 1'b0);
		set_row(12, encode_b(3'h1), ra[1], ra[1], 6'd13, EXP_BRANCH, '0, 1'b0);
		set_row(13, encode_b(3'h1), ra[1], ra[1] ^ 32'h8000_0000, 6'd14, EXP_BRANCH, '0, 1'b1);
		set_row(14, encode_s(12'h008), `DMEM_BASE, 32'hdead_beef, 6'd15, EXP_NONE, '0, 1'b0);
		set_row(15, encode_i(12'h008, 3'h2, 7'h03), `DMEM_BASE, '0, 6'd16, EXP_RESULT,
			32'hdead_beef, 1'b0);
		// word 5 is never written
		set_row(16, encode_i(12'h014, 3'h2, 7'h03), `DMEM_BASE, '0, 6'd17, EXP_RESULT, '0, 1'b0);
		set_row(17, encode_s(12'hffc), `DMEM_BASE + 32'd16, st_data, 6'd18, EXP_NONE, '0, 1'b0);
		set_row(18, encode_i(12'h004, 3'h2, 7'h03), `DMEM_BASE + 32'd8, '0, 6'd19, EXP_RESULT,
			st_data, 1'b0);
		set_row(19, 32'h0000_007f, ra[2], rb[2], 6'd20, EXP_NONE, '0, 1'b0);
		set_row(20, encode_r(7'h00, 3'h0), ra[2], rb[2], 6'h3f, EXP_RESULT, ra[2] + rb[2], 1'b0);
	endtask

	task automatic report_mismatch(input string what);
		$display("Mismatch at %0t ns: %s", $time, what);
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_result(input tag_t tag, input xlen_t data);
		if (cdb_valid !== 1'b1 || cdb_branch !== 1'b0)
			report_mismatch($sformatf("valid %b branch %b, expected a result", cdb_valid,
				cdb_branch));
		else if (cdb_tag !== tag)
			report_mismatch($sformatf("cdb_tag got %h expected %h", cdb_tag, tag));
		else if (cdb_data !== data)
			report_mismatch($sformatf("cdb_data got %h expected %h", cdb_data, data));
	endtask

	task automatic check_branch(input logic taken);
		if (cdb_branch !== 1'b1 || cdb_valid !== 1'b0)
			report_mismatch($sformatf("branch %b valid %b, expected a branch", cdb_branch,
				cdb_valid));
		else if (cdb_branch_taken !== taken)
			report_mismatch($sformatf("cdb_branch_taken got %b expected %b",
				cdb_branch_taken, taken));
		else if (cdb_tag !== '0 || cdb_data !== '0)
			report_mismatch($sformatf("branch tag %h data %h, expected zero", cdb_tag,
				cdb_data));
	endtask

	task automatic check_silent();
		if (cdb_valid !== 1'b0 || cdb_branch !== 1'b0)
			report_mismatch($sformatf("valid %b branch %b, expected an idle CDB", cdb_valid,
				cdb_branch));
	endtask

	// an issue seen here is sampled at the next edge, result due three edges on
	always @(negedge clk) begin
		if (!reset) begin
			if (due_q.size() != 0 && due_q[0] == neg_cnt) begin
				void'(due_q.pop_front());
				cur = exp_q.pop_front();
				case (cur.kind)
					EXP_RESULT: check_result(cur.tag, cur.data);
					EXP_BRANCH: check_branch(cur.taken);
					default:    check_silent();
				endcase
			end else begin
				check_silent();
			end
		end
		if (issue_valid)
			due_q.push_back(neg_cnt + 3);
		neg_cnt++;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: results did not drain after %0d cycles", cycles);
			$display("Simulation FAILED");
			$fatal(1, "timeout: results did not drain");
		end
	end

	initial begin
		neg_cnt = 0;
		cycles = 0;
		reset <= 1'b1;
		issue_valid <= 1'b0;
		instr <= '0;
		rs1_data <= '0;
		rs2_data <= '0;
		rd_tag <= '0;
		void'($urandom(39438));
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		// one row per clock, no gaps
		for (int i = 0; i < N_ROWS; i++) begin
			@(posedge clk);
			issue_valid <= 1'b1;
			instr <= rows[i].word;
			rs1_data <= rows[i].a;
			rs2_data <= rows[i].b;
			rd_tag <= rows[i].tag;
			exp_q.push_back(rows[i]);
		end
		@(posedge clk);
		issue_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		// two more idle CDB checks complete before the end
		repeat (3) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule
